/* Makefile */
# Verilator flow for the sprite engine testbench

TOP = tb_game_sprite
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f game_sprite.f

sim:
	verilator --binary -j 0 --assert --top-module $(TOP) -f game_sprite.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

/* bench/game_sprite_golden.txt */
// kind_a_b_c in hex, kind 00 ends the list
// 01 write addr data, 02 read addr data, 03 probe x y rgb, 04 status bit7 rise, 05 wait frame
// register read-back, unmapped addresses read zero
01_00_04_00
01_04_02_00
01_08_02_00
02_00_04_00
02_04_02_00
02_08_02_00
01_02_07_00
02_02_00_00
02_0d_00_00
// sprite at (4, 2) over background colour 2
03_07_02_04
03_04_05_04
03_04_02_02
03_0e_0a_02
// moved sprite shows from the next frame on
01_00_09_00
03_0c_02_04
03_07_02_02
// status with the sprite past the right edge, then inside again
01_00_0c_00
03_0f_02_04
04_00_ff_00
05_00_00_00
04_00_01_00
01_00_04_00
03_07_02_04
04_01_ff_00
05_00_00_00
04_01_01_00
00_00_00_00

/* bench/tb_game_sprite.sv */
`timescale 1ns/1ns

`include "game_defs.svh"

module tb_game_sprite;

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_RECORDS  = 64;

    // raster scanner to the output pins
    localparam int PIPE_LATENCY = 3;

    // setup, access and the idle cycle that follows
    localparam int XFER_CYCLES  = 3;

    localparam logic [7:0] KIND_END    = 8'h00;
    localparam logic [7:0] KIND_WRITE  = 8'h01;
    localparam logic [7:0] KIND_READ   = 8'h02;
    localparam logic [7:0] KIND_PROBE  = 8'h03;
    localparam logic [7:0] KIND_STATUS = 8'h04;
    localparam logic [7:0] KIND_FRAME  = 8'h05;
    localparam logic [7:0] NO_RISE     = 8'hff;

    logic                         clk;
    logic                         reset;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [`APB_ADDR_WIDTH - 1:0] paddr;
    logic [`APB_DATA_WIDTH - 1:0] pwdata;
    logic [`APB_DATA_WIDTH - 1:0] prdata;
    logic                         pready;
    logic                         out_valid;
    logic [`X_WIDTH - 1:0]        out_x;
    logic [`Y_WIDTH - 1:0]        out_y;
    logic [`RGB_WIDTH - 1:0]      out_rgb;

    // kind, then three byte fields per record
    logic [31:0]                  golden [0:MAX_RECORDS - 1];
    int                           num_records;
    bit                           loaded;
    int                           failed;
    logic [6:0]                   last_count;
    bit                           have_count;

    game_sprite_top game_sprite_top_i
    (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .out_valid (out_valid),
        .out_x     (out_x),
        .out_y     (out_y),
        .out_rgb   (out_rgb)
    );

    initial
        clk = 1'b0;

    always
        #HALF_PERIOD clk = ~clk;

    task automatic report_mismatch(input string name, input logic [7:0] actual,
                                   input logic [7:0] expected);
        $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, actual, expected);
    endtask

    // inside the visible area of the screen
    function automatic logic pixel_visible(input logic [`X_WIDTH - 1:0] x,
                                           input logic [`Y_WIDTH - 1:0] y);
        return (x < `X_WIDTH'(`SCREEN_WIDTH)) && (y < `Y_WIDTH'(`SCREEN_HEIGHT));
    endfunction

    // ***********************************************************
    // bus and pixel helpers
    // ***********************************************************

    // read data is sampled in the access cycle, after the setup edge loaded it
    task automatic apb_transfer(input logic write, input logic [`APB_ADDR_WIDTH - 1:0] addr,
                                input logic [`APB_DATA_WIDTH - 1:0] wdata,
                                output logic [`APB_DATA_WIDTH - 1:0] rdata);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        rdata   = prdata;
        if (pready !== 1'b1)
        begin
            report_mismatch("pready", 8'(pready), 8'h01);
            failed++;
        end
        @(posedge clk);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // skip frames that were already in the pipe before the last write
    task automatic probe_pixel(input logic [`X_WIDTH - 1:0] x, input logic [`Y_WIDTH - 1:0] y,
                               output logic [`RGB_WIDTH - 1:0] rgb, output bit ok);
        bit started;
        bit found;

        started = 1'b0;
        found   = 1'b0;
        ok      = 1'b1;
        repeat (PIPE_LATENCY) @(posedge clk);
        while (!found)
        begin
            @(negedge clk);
            // out_valid follows the visible area at every pixel passed
            if (ok && out_valid !== pixel_visible(out_x, out_y))
            begin
                report_mismatch("out_valid", 8'(out_valid), 8'(pixel_visible(out_x, out_y)));
                ok = 1'b0;
            end
            if (out_x == '0 && out_y == '0)
                started = 1'b1;
            if (started && out_valid && out_x == x && out_y == y)
                found = 1'b1;
        end
        rgb = out_rgb;
    endtask

    // ***********************************************************
    // golden records
    // ***********************************************************

    initial
    begin
        logic [7:0]                   kind;
        logic [7:0]                   fa;
        logic [7:0]                   fb;
        logic [7:0]                   fc;
        logic [`APB_DATA_WIDTH - 1:0] rdata;
        logic [`RGB_WIDTH - 1:0]      rgb;
        logic [6:0]                   rise;
        bit                           ok;
        int                           idx;

        reset      = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        failed     = 0;
        have_count = 1'b0;
        last_count = '0;
        loaded     = 1'b0;

        for (idx = 0; idx < MAX_RECORDS; idx++)
            golden[idx] = '0;
        $readmemh("bench/game_sprite_golden.txt", golden);
        num_records = 0;
        while (num_records < MAX_RECORDS && golden[num_records][31:24] != KIND_END)
            num_records++;
        if (num_records == 0)
        begin
            $display("golden file holds no records");
            failed++;
        end
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        for (idx = 0; idx < num_records; idx++)
        begin
            {kind, fa, fb, fc} = golden[idx];
            ok = 1'b1;
            case (kind)
                KIND_WRITE:
                begin
                    apb_transfer(1'b1, fa[`APB_ADDR_WIDTH - 1:0], fb, rdata);
                    $display("test %0d: write 0x%h to address 0x%h, done", idx, fb, fa);
                end
                KIND_READ:
                begin
                    apb_transfer(1'b0, fa[`APB_ADDR_WIDTH - 1:0], '0, rdata);
                    if (rdata !== fb)
                    begin
                        report_mismatch("prdata", rdata, fb);
                        ok = 1'b0;
                    end
                    $display("test %0d: read address 0x%h, %s", idx, fa, ok ? "ok" : "mismatch");
                end
                KIND_PROBE:
                begin
                    probe_pixel(fa[`X_WIDTH - 1:0], fb[`Y_WIDTH - 1:0], rgb, ok);
                    if (rgb !== fc[`RGB_WIDTH - 1:0])
                    begin
                        report_mismatch("out_rgb", 8'(rgb), 8'(fc[`RGB_WIDTH - 1:0]));
                        ok = 1'b0;
                    end
                    $display("test %0d: pixel (%0d, %0d), %s", idx, fa, fb,
                             ok ? "ok" : "mismatch");
                end
                KIND_STATUS:
                begin
                    apb_transfer(1'b0, game_pkg::REG_STATUS, '0, rdata);
                    rise = rdata[6:0] - last_count;
                    if (rdata[7] !== fa[0])
                    begin
                        report_mismatch("prdata[7]", 8'(rdata[7]), 8'(fa[0]));
                        ok = 1'b0;
                    end
                    if (have_count && fb != NO_RISE && rise !== fb[6:0])
                    begin
                        report_mismatch("frame count rise", 8'(rise), 8'(fb[6:0]));
                        ok = 1'b0;
                    end
                    last_count = rdata[6:0];
                    have_count = 1'b1;
                    $display("test %0d: status read, %s", idx, ok ? "ok" : "mismatch");
                end
                KIND_FRAME:
                begin
                    // next transfer starts one full frame after the previous one
                    repeat (FRAME_CYCLES - XFER_CYCLES) @(negedge clk);
                    $display("test %0d: waited one frame", idx);
                end
                default:
                begin
                    $display("test %0d: unknown record kind 0x%h", idx, kind);
                    ok = 1'b0;
                end
            endcase
            if (!ok)
                failed++;
        end

        $display("%0d tests run, %0d failed", num_records, failed);
        if (failed == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // two frames per record covers the slowest probe
    initial
    begin
        wait (loaded);
        repeat (RESET_CYCLES + num_records * 2 * FRAME_CYCLES) @(posedge clk);
        $display("watchdog expired before all golden records were run");
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* common/game_defs.svh */
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// ***********************************************************
// pixel coordinate and colour widths
// ***********************************************************

`define X_WIDTH        5
`define Y_WIDTH        4
`define RGB_WIDTH      3

// visible area, then totals including blanking
`define SCREEN_WIDTH   16
`define SCREEN_HEIGHT  12
`define H_TOTAL        20
`define V_TOTAL        14

// square sprite, width and height
`define SPRITE_SIZE    8

// register port
`define APB_ADDR_WIDTH 4
`define APB_DATA_WIDTH 8

`endif

/* common/game_pkg.sv */
`include "game_defs.svh"

package game_pkg;

    // ***********************************************************
    // register port
    // ***********************************************************

    typedef enum logic [1:0]
    {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_t;

    // the address of a transfer selects the register
    typedef enum logic [`APB_ADDR_WIDTH - 1:0]
    {
        REG_SPRITE_X  = 4'd0,
        REG_SPRITE_Y  = 4'd4,
        REG_BG_RGB    = 4'd8,
        REG_STATUS    = 4'd12
    } reg_addr_t;

    // ***********************************************************
    // sprite bitmap
    // ***********************************************************

    typedef struct packed
    {
        logic                    en;
        logic [`RGB_WIDTH - 1:0] rgb;
    } sprite_entry_t;

    // column 0 sits in the most significant nibble
    typedef sprite_entry_t [0:`SPRITE_SIZE - 1] sprite_row_t;

    // plus sign in colour 4, entry 4'hc is enable plus colour
    localparam sprite_row_t SPRITE_BITMAP [0:`SPRITE_SIZE - 1] = '{
        32'h000cc000,
        32'h000cc000,
        32'h000cc000,
        32'hcccccccc,
        32'hcccccccc,
        32'h000cc000,
        32'h000cc000,
        32'h000cc000
    };

endpackage

/* common/pixel_if.sv */
`timescale 1ns/1ns

`include "game_defs.svh"

// one pixel of the raster stream, advancing every clock
interface pixel_if;

    // inside the visible area
    logic                  active;

    logic [`X_WIDTH - 1:0] x;
    logic [`Y_WIDTH - 1:0] y;

    // first pixel of a line, first pixel of a frame
    logic                  line_start;
    logic                  frame_start;

    modport source
    (
        output active,
        output x,
        output y,
        output line_start,
        output frame_start
    );

    modport sink
    (
        input  active,
        input  x,
        input  y,
        input  line_start,
        input  frame_start
    );

endinterface

/* game_sprite.f */
+incdir+common
common/game_pkg.sv
common/pixel_if.sv
src/raster_scan.sv
src/apb_sprite_regs.sv
sprite/sprite_display.sv
src/pixel_mixer.sv
src/game_sprite_top.sv
bench/tb_game_sprite.sv

/* sprite/sprite_display.sv */
`timescale 1ns/1ns

`include "game_defs.svh"

module sprite_display
(
    input  logic                    clk,
    input  logic                    reset,

    pixel_if.sink                   pix_in,
    pixel_if.source                 pix_out,

    input  logic [`X_WIDTH - 1:0]   sprite_x,
    input  logic [`Y_WIDTH - 1:0]   sprite_y,

    output logic                    hit,
    output logic [`RGB_WIDTH - 1:0] sprite_rgb,
    output logic                    on_screen
);

    localparam int IDX_WIDTH = $clog2(`SPRITE_SIZE);

    // the extra top bit is a sign or a carry
    logic [`X_WIDTH:0]       x_off;
    logic [`X_WIDTH:0]       x_right;
    logic [`Y_WIDTH:0]       y_off;
    logic [`Y_WIDTH:0]       y_bottom;
    logic                    x_fit;
    logic                    y_fit;

    logic [`X_WIDTH - 1:0]   r1_x;
    logic [`Y_WIDTH - 1:0]   r1_y;
    logic [`X_WIDTH:0]       r1_x_off;
    logic [`X_WIDTH:0]       r1_x_right;
    logic [`Y_WIDTH:0]       r1_y_off;
    logic [`Y_WIDTH:0]       r1_y_bottom;
    logic                    r1_active;
    logic                    r1_line_start;
    logic                    r1_frame_start;
    logic                    r1_on_screen;

    logic [`X_WIDTH:0]       x_to_right;
    logic [`Y_WIDTH:0]       y_to_bottom;
    logic                    x_hit;
    logic                    y_hit;
    game_pkg::sprite_entry_t entry;

    // ***********************************************************
    // stage one, offsets and edges
    // ***********************************************************

    assign x_off    = { 1'b0, pix_in.x } - { 1'b0, sprite_x };
    assign y_off    = { 1'b0, pix_in.y } - { 1'b0, sprite_y };
    assign x_right  = { 1'b0, sprite_x } + (`X_WIDTH + 1)'(`SPRITE_SIZE - 1);
    assign y_bottom = { 1'b0, sprite_y } + (`Y_WIDTH + 1)'(`SPRITE_SIZE - 1);

    // whole sprite inside the visible area
    assign x_fit = x_right  < (`X_WIDTH + 1)'(`SCREEN_WIDTH);
    assign y_fit = y_bottom < (`Y_WIDTH + 1)'(`SCREEN_HEIGHT);

    always_ff @(posedge clk)
    begin
        r1_x        <= pix_in.x;
        r1_y        <= pix_in.y;
        r1_x_off    <= x_off;
        r1_y_off    <= y_off;
        r1_x_right  <= x_right;
        r1_y_bottom <= y_bottom;
    end

    always_ff @(posedge clk or posedge reset)
        if (reset)
        begin
            r1_active      <= 1'b0;
            r1_line_start  <= 1'b0;
            r1_frame_start <= 1'b0;
            r1_on_screen   <= 1'b0;
        end
        else
        begin
            r1_active      <= pix_in.active;
            r1_line_start  <= pix_in.line_start;
            r1_frame_start <= pix_in.frame_start;
            r1_on_screen   <= x_fit && y_fit;
        end

    // ***********************************************************
    // stage two, hit test and bitmap lookup
    // ***********************************************************

    // negative means the pixel lies past the right or bottom edge
    assign x_to_right  = r1_x_right  - { 1'b0, r1_x };
    assign y_to_bottom = r1_y_bottom - { 1'b0, r1_y };

    assign x_hit = !r1_x_off[`X_WIDTH] && !x_to_right[`X_WIDTH];
    assign y_hit = !r1_y_off[`Y_WIDTH] && !y_to_bottom[`Y_WIDTH];

    assign entry = game_pkg::SPRITE_BITMAP[r1_y_off[IDX_WIDTH - 1:0]][r1_x_off[IDX_WIDTH - 1:0]];

    always_ff @(posedge clk or posedge reset)
        if (reset)
        begin
            hit                 <= 1'b0;
            on_screen           <= 1'b0;
            pix_out.active      <= 1'b0;
            pix_out.line_start  <= 1'b0;
            pix_out.frame_start <= 1'b0;
        end
        else
        begin
            hit                 <= r1_active && x_hit && y_hit && entry.en;
            on_screen           <= r1_on_screen;
            pix_out.active      <= r1_active;
            pix_out.line_start  <= r1_line_start;
            pix_out.frame_start <= r1_frame_start;
        end

    always_ff @(posedge clk)
    begin
        sprite_rgb <= entry.rgb;
        pix_out.x  <= r1_x;
        pix_out.y  <= r1_y;
    end

    // blanking pixels never carry sprite colour
    a_hit_active : assert property (
        @(posedge clk) disable iff (reset)
            hit |-> (pix_out.x < `X_WIDTH'(`SCREEN_WIDTH))
                 && (pix_out.y < `Y_WIDTH'(`SCREEN_HEIGHT))
    )
    else
        $error("sprite hit outside the visible area");

endmodule

/* src/apb_sprite_regs.sv */
`timescale 1ns/1ns

`include "game_defs.svh"

module apb_sprite_regs
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [`APB_ADDR_WIDTH - 1:0]  paddr,
    input  logic [`APB_DATA_WIDTH - 1:0]  pwdata,
    output logic [`APB_DATA_WIDTH - 1:0]  prdata,
    output logic                          pready,

    pixel_if.sink                         pix,

    input  logic [7:0]                    frame_count,
    input  logic                          last_on_screen,

    output logic [`X_WIDTH - 1:0]         sprite_x,
    output logic [`Y_WIDTH - 1:0]         sprite_y,
    output logic [`RGB_WIDTH - 1:0]       bg_rgb
);

    game_pkg::apb_state_t            phase;
    game_pkg::reg_addr_t             addr_op;

    logic                            wr_en;
    logic                            rd_setup;
    logic [`APB_DATA_WIDTH - 1:0]    rd_mux;

    // written by the bus
    logic [`X_WIDTH - 1:0]           stage_x;
    logic [`Y_WIDTH - 1:0]           stage_y;
    logic [`RGB_WIDTH - 1:0]         stage_bg;

    // held for the running frame
    logic [`X_WIDTH - 1:0]           shadow_x;
    logic [`Y_WIDTH - 1:0]           shadow_y;
    logic [`RGB_WIDTH - 1:0]         shadow_bg;

    // ***********************************************************
    // bus phase and decode
    // ***********************************************************

    always_comb
        if (psel && penable)
            phase = game_pkg::APB_ACCESS;
        else if (psel)
            phase = game_pkg::APB_SETUP;
        else
            phase = game_pkg::APB_IDLE;

    assign addr_op  = game_pkg::reg_addr_t'(paddr);
    assign pready   = 1'b1;
    assign wr_en    = (phase == game_pkg::APB_ACCESS) && pwrite;
    assign rd_setup = (phase == game_pkg::APB_SETUP) && !pwrite;

    always_ff @(posedge clk or posedge reset)
        if (reset)
        begin
            stage_x  <= '0;
            stage_y  <= '0;
            stage_bg <= '0;
        end
        else if (wr_en)
        begin
            case (addr_op)
                game_pkg::REG_SPRITE_X: stage_x  <= pwdata[`X_WIDTH - 1:0];
                game_pkg::REG_SPRITE_Y: stage_y  <= pwdata[`Y_WIDTH - 1:0];
                game_pkg::REG_BG_RGB:   stage_bg <= pwdata[`RGB_WIDTH - 1:0];
                default:                ;
            endcase
        end

    always_comb
        case (addr_op)
            game_pkg::REG_SPRITE_X: rd_mux = `APB_DATA_WIDTH'(stage_x);
            game_pkg::REG_SPRITE_Y: rd_mux = `APB_DATA_WIDTH'(stage_y);
            game_pkg::REG_BG_RGB:   rd_mux = `APB_DATA_WIDTH'(stage_bg);
            game_pkg::REG_STATUS:   rd_mux = { last_on_screen, frame_count[6:0] };
            default:                rd_mux = '0;
        endcase

    // loaded in setup so the data is there for the access cycle
    always_ff @(posedge clk or posedge reset)
        if (reset)
            prdata <= '0;
        else if (rd_setup)
            prdata <= rd_mux;
        else if (phase != game_pkg::APB_ACCESS)
            prdata <= '0;

    // ***********************************************************
    // frame start copy
    // ***********************************************************

    always_ff @(posedge clk or posedge reset)
        if (reset)
        begin
            shadow_x  <= '0;
            shadow_y  <= '0;
            shadow_bg <= '0;
        end
        else if (pix.frame_start)
        begin
            shadow_x  <= stage_x;
            shadow_y  <= stage_y;
            shadow_bg <= stage_bg;
        end

    // first pixel of a frame already needs the new values
    assign sprite_x = pix.frame_start ? stage_x  : shadow_x;
    assign sprite_y = pix.frame_start ? stage_y  : shadow_y;
    assign bg_rgb   = pix.frame_start ? stage_bg : shadow_bg;

    a_penable_psel : assert property (
        @(posedge clk) disable iff (reset) penable |-> psel
    )
    else
        $error("penable high without psel");

    a_paddr_stable : assert property (
        @(posedge clk) disable iff (reset)
            (phase == game_pkg::APB_SETUP) ##1 (phase == game_pkg::APB_ACCESS)
                |-> $stable(paddr)
    )
    else
        $error("paddr changed between setup and access");

endmodule

/* src/game_sprite_top.sv */
`timescale 1ns/1ns

`include "game_defs.svh"

module game_sprite_top
(
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [`APB_ADDR_WIDTH - 1:0] paddr,
    input  logic [`APB_DATA_WIDTH - 1:0] pwdata,
    output logic [`APB_DATA_WIDTH - 1:0] prdata,
    output logic                         pready,

    output logic                         out_valid,
    output logic [`X_WIDTH - 1:0]        out_x,
    output logic [`Y_WIDTH - 1:0]        out_y,
    output logic [`RGB_WIDTH - 1:0]      out_rgb
);

    // raster output, then the stream delayed past the sprite test
    pixel_if scan_pix ();
    pixel_if disp_pix ();

    logic [`X_WIDTH - 1:0]   sprite_x;
    logic [`Y_WIDTH - 1:0]   sprite_y;
    logic [`RGB_WIDTH - 1:0] bg_rgb;

    logic                    hit;
    logic [`RGB_WIDTH - 1:0] sprite_rgb;
    logic                    on_screen;

    logic [7:0]              frame_count;
    logic                    last_on_screen;

    raster_scan raster_scan_i
    (
        .clk            (clk),
        .reset          (reset),
        .pix            (scan_pix.source)
    );

    apb_sprite_regs apb_sprite_regs_i
    (
        .clk            (clk),
        .reset          (reset),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pix            (scan_pix.sink),
        .frame_count    (frame_count),
        .last_on_screen (last_on_screen),
        .sprite_x       (sprite_x),
        .sprite_y       (sprite_y),
        .bg_rgb         (bg_rgb)
    );

    sprite_display sprite_display_i
    (
        .clk            (clk),
        .reset          (reset),
        .pix_in         (scan_pix.sink),
        .pix_out        (disp_pix.source),
        .sprite_x       (sprite_x),
        .sprite_y       (sprite_y),
        .hit            (hit),
        .sprite_rgb     (sprite_rgb),
        .on_screen      (on_screen)
    );

    pixel_mixer pixel_mixer_i
    (
        .clk            (clk),
        .reset          (reset),
        .pix            (disp_pix.sink),
        .hit            (hit),
        .sprite_rgb     (sprite_rgb),
        .on_screen      (on_screen),
        .bg_rgb         (bg_rgb),
        .out_valid      (out_valid),
        .out_x          (out_x),
        .out_y          (out_y),
        .out_rgb        (out_rgb),
        .frame_count    (frame_count),
        .last_on_screen (last_on_screen)
    );

endmodule

/* src/pixel_mixer.sv */
`timescale 1ns/1ns

`include "game_defs.svh"

module pixel_mixer
(
    input  logic                    clk,
    input  logic                    reset,

    pixel_if.sink                   pix,

    input  logic                    hit,
    input  logic [`RGB_WIDTH - 1:0] sprite_rgb,
    input  logic                    on_screen,
    input  logic [`RGB_WIDTH - 1:0] bg_rgb,

    output logic                    out_valid,
    output logic [`X_WIDTH - 1:0]   out_x,
    output logic [`Y_WIDTH - 1:0]   out_y,
    output logic [`RGB_WIDTH - 1:0] out_rgb,

    output logic [7:0]              frame_count,
    output logic                    last_on_screen
);

    // ***********************************************************
    // per-frame status
    // ***********************************************************

    always_ff @(posedge clk or posedge reset)
        if (reset)
        begin
            out_valid      <= 1'b0;
            frame_count    <= '0;
            last_on_screen <= 1'b0;
        end
        else
        begin
            out_valid <= pix.active;

            if (pix.frame_start)
            begin
                frame_count    <= frame_count + 1'b1;
                last_on_screen <= on_screen;
            end
        end

    // sprite over background, black during blanking
    always_ff @(posedge clk)
    begin
        out_x <= pix.x;
        out_y <= pix.y;

        if (!pix.active)
            out_rgb <= '0;
        else if (hit)
            out_rgb <= sprite_rgb;
        else
            out_rgb <= bg_rgb;
    end

endmodule

/* src/raster_scan.sv */
`timescale 1ns/1ns

`include "game_defs.svh"

module raster_scan
(
    input  logic    clk,
    input  logic    reset,

    pixel_if.source pix
);

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;

    logic [`X_WIDTH - 1:0] h_cnt;
    logic [`Y_WIDTH - 1:0] v_cnt;

    logic                  h_last;
    logic                  v_last;

    assign h_last = (h_cnt == `X_WIDTH'(`H_TOTAL - 1));
    assign v_last = (v_cnt == `Y_WIDTH'(`V_TOTAL - 1));

    // ***********************************************************
    // counters
    // ***********************************************************

    always_ff @(posedge clk or posedge reset)
        if (reset)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_last)
        begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end

    // registered so that nothing is marked while reset holds the counters
    always_ff @(posedge clk or posedge reset)
        if (reset)
        begin
            pix.active      <= 1'b0;
            pix.x           <= '0;
            pix.y           <= '0;
            pix.line_start  <= 1'b0;
            pix.frame_start <= 1'b0;
        end
        else
        begin
            pix.active      <= (h_cnt < `X_WIDTH'(`SCREEN_WIDTH))
                            && (v_cnt < `Y_WIDTH'(`SCREEN_HEIGHT));
            pix.x           <= h_cnt;
            pix.y           <= v_cnt;
            pix.line_start  <= (h_cnt == '0);
            pix.frame_start <= (h_cnt == '0) && (v_cnt == '0);
        end

    // one frame marker per full frame, none in between
    a_frame_period : assert property (
        @(posedge clk) disable iff (reset)
            pix.frame_start |=> (!pix.frame_start) [*FRAME_CYCLES - 1] ##1 pix.frame_start
    )
    else
        $error("frame_start period differs from %0d cycles", FRAME_CYCLES);

endmodule
